/* source/versatDataPkg.sv */
package versatDataPkg;

   // datapath word
   localparam int dataW = 32;

   // 64 words per memory
   localparam int memAddrW = 6;

   // top bit picks the memory
   localparam int hostAddrW = memAddrW + 1;

   // two streams then mem0 A, mem0 B, mem1 A, mem1 B
   localparam int busSlots = 6;
   localparam int selW = 3;
   localparam int busW = busSlots * dataW;

   typedef logic [dataW-1:0]     dataWord;
   typedef logic [memAddrW-1:0]  memAddr;
   typedef logic [hostAddrW-1:0] hostAddr;
   typedef logic [selW-1:0]      busSel;

   // slot 0 sits in the low word
   typedef logic [busW-1:0]      dataBus;

endpackage

/* source/memConfigPkg.sv */
package memConfigPkg;

   // field widths
   localparam int iterFieldW = 6;
   localparam int periodW = 5;
   localparam int selFieldW = 3;
   localparam int addrFieldW = 6;

   typedef logic [periodW-1:0] periodCount;

   // field offsets, lsb first
   localparam int writeOff = 0;
   localparam int extOff = 1;
   localparam int reverseOff = 2;
   localparam int delayOff = 3;
   localparam int incrOff = delayOff + periodW;
   localparam int shiftOff = incrOff + addrFieldW;
   localparam int startOff = shiftOff + addrFieldW;
   localparam int selOff = startOff + addrFieldW;
   localparam int dutyOff = selOff + selFieldW;
   localparam int periodOff = dutyOff + periodW;
   localparam int iterOff = periodOff + periodW;

   localparam int portConfigW = iterOff + iterFieldW;
   typedef logic [portConfigW-1:0] portConfig;

   // port A in the upper half
   localparam int memConfigW = 2 * portConfigW;
   typedef logic [memConfigW-1:0] memConfig;

endpackage

/* source/dataBusSelect.sv */
module dataBusSelect (
   input  versatDataPkg::busSel   sel,
   input  versatDataPkg::dataBus  bus,
   output versatDataPkg::dataWord data
);

   import versatDataPkg::*;

   logic inRange;

   assign inRange = int'(sel) < busSlots;

   // codes past the last slot read as zero
   always_comb
   begin
      if (inRange)
      begin
         data = bus[int'(sel)*dataW +: dataW];
      end
      else
      begin
         data = '0;
      end
   end

endmodule

/* source/addressGenerator.sv */
module addressGenerator (
   input  logic                     clk,
   input  logic                     reset,
   input  logic                     run,
   input  versatDataPkg::memAddr    iterations,
   input  versatDataPkg::memAddr    start,
   input  versatDataPkg::memAddr    shift,
   input  versatDataPkg::memAddr    incr,
   input  memConfigPkg::periodCount period,
   input  memConfigPkg::periodCount duty,
   input  memConfigPkg::periodCount delay,
   output versatDataPkg::memAddr    addr,
   output logic                     enable,
   output logic                     done
);

   import versatDataPkg::*;
   import memConfigPkg::*;

   typedef enum logic [1:0] {
      idle,
      waitDelay,
      looping
   } genState;

   genState    state;
   periodCount delayCnt;
   periodCount periodCnt;
   memAddr     iterCnt;
   memAddr     base;
   memAddr     pointer;
   logic       lastInPeriod;
   logic       lastIter;

   assign lastInPeriod = periodCnt == period - 1'b1;
   assign lastIter = iterCnt == iterations - 1'b1;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state <= idle;
         delayCnt <= '0;
         periodCnt <= '0;
         iterCnt <= '0;
         base <= '0;
         pointer <= '0;
      end
      else
      begin
         case (state)
            idle:
            begin
               if (run)
               begin
                  // load the loop so the first cycle needs no setup
                  delayCnt <= delay - 1'b1;
                  periodCnt <= '0;
                  iterCnt <= '0;
                  base <= start;
                  pointer <= start;
                  if (delay == '0)
                     state <= looping;
                  else
                     state <= waitDelay;
               end
            end
            waitDelay:
            begin
               if (delayCnt == '0)
                  state <= looping;
               else
                  delayCnt <= delayCnt - 1'b1;
            end
            looping:
            begin
               if (lastInPeriod)
               begin
                  // next iteration restarts from the shifted base
                  periodCnt <= '0;
                  iterCnt <= iterCnt + 1'b1;
                  base <= base + shift;
                  pointer <= base + shift;
                  if (lastIter)
                     state <= idle;
               end
               else
               begin
                  periodCnt <= periodCnt + 1'b1;
                  pointer <= pointer + incr;
               end
            end
            default:
               state <= idle;
         endcase
      end
   end

   assign addr = pointer;
   assign enable = (state == looping) && (periodCnt < duty);
   assign done = state == idle;

endmodule

/* source/dualPortRam.sv */
module dualPortRam (
   input  logic                   clk,
   input  logic                   enA,
   input  logic                   enB,
   input  logic                   weA,
   input  logic                   weB,
   input  versatDataPkg::memAddr  addrA,
   input  versatDataPkg::memAddr  addrB,
   input  versatDataPkg::dataWord dataA,
   input  versatDataPkg::dataWord dataB,
   output versatDataPkg::dataWord qA,
   output versatDataPkg::dataWord qB
);

   import versatDataPkg::*;

   dataWord mem [0:(1 << memAddrW) - 1];

   // both ports in one block, B written last so it wins a collision
   always_ff @(posedge clk)
   begin
      if (enA && weA)
         mem[addrA] <= dataA;
      if (enB && weB)
         mem[addrB] <= dataB;
   end

   // read old data, hold when idle
   always_ff @(posedge clk)
   begin
      if (enA)
         qA <= mem[addrA];
      if (enB)
         qB <= mem[addrB];
   end

endmodule

/* source/memoryUnit.sv */
module memoryUnit (
   input  logic                    clk,
   input  logic                    reset,
   input  logic                    run,
   input  logic                    valid,
   input  logic                    we,
   input  versatDataPkg::memAddr   addr,
   input  versatDataPkg::dataWord  hostData,
   input  versatDataPkg::dataBus   bus,
   input  memConfigPkg::memConfig  cfg,
   output versatDataPkg::dataWord  outA,
   output versatDataPkg::dataWord  outB,
   output logic                    doneA,
   output logic                    doneB
);

   import versatDataPkg::*;
   import memConfigPkg::*;

   portConfig  cfgA;
   portConfig  cfgB;
   memAddr     iterA, startA, shiftA, incrA;
   memAddr     iterB, startB, shiftB, incrB;
   periodCount periodA, dutyA, delayA;
   periodCount periodB, dutyB, delayB;
   busSel      selA, selB;
   logic       reverseA, extA, writeA;
   logic       reverseB, extB, writeB;
   memAddr     genAddrA, genAddrB;
   memAddr     ramAddrA, ramAddrB;
   logic       genEnA, genEnB;
   logic       ramEnA, weA, weB;
   dataWord    inA, inB, ramDataA;

   function automatic memAddr mirror(input memAddr a);
      memAddr r;
      for (int i = 0; i < memAddrW; i++)
         r[i] = a[memAddrW-1-i];
      return r;
   endfunction

   assign cfgA = cfg[portConfigW +: portConfigW];
   assign cfgB = cfg[0 +: portConfigW];

   assign iterA = cfgA[iterOff +: iterFieldW];
   assign periodA = cfgA[periodOff +: periodW];
   assign dutyA = cfgA[dutyOff +: periodW];
   assign selA = cfgA[selOff +: selFieldW];
   assign startA = cfgA[startOff +: addrFieldW];
   assign shiftA = cfgA[shiftOff +: addrFieldW];
   assign incrA = cfgA[incrOff +: addrFieldW];
   assign delayA = cfgA[delayOff +: periodW];
   assign reverseA = cfgA[reverseOff];
   assign extA = cfgA[extOff];
   assign writeA = cfgA[writeOff];

   assign iterB = cfgB[iterOff +: iterFieldW];
   assign periodB = cfgB[periodOff +: periodW];
   assign dutyB = cfgB[dutyOff +: periodW];
   assign selB = cfgB[selOff +: selFieldW];
   assign startB = cfgB[startOff +: addrFieldW];
   assign shiftB = cfgB[shiftOff +: addrFieldW];
   assign incrB = cfgB[incrOff +: addrFieldW];
   assign delayB = cfgB[delayOff +: periodW];
   assign reverseB = cfgB[reverseOff];
   assign extB = cfgB[extOff];
   assign writeB = cfgB[writeOff];

   dataBusSelect selA_i (.sel(selA), .bus(bus), .data(inA));
   dataBusSelect selB_i (.sel(selB), .bus(bus), .data(inB));

   // unprogrammed ports never leave idle
   addressGenerator genA_i (
      .clk(clk), .reset(reset), .run(run & (|iterA)),
      .iterations(iterA), .start(startA), .shift(shiftA), .incr(incrA),
      .period(periodA), .duty(dutyA), .delay(delayA),
      .addr(genAddrA), .enable(genEnA), .done(doneA)
   );

   addressGenerator genB_i (
      .clk(clk), .reset(reset), .run(run & (|iterB)),
      .iterations(iterB), .start(startB), .shift(shiftB), .incr(incrB),
      .period(periodB), .duty(dutyB), .delay(delayB),
      .addr(genAddrB), .enable(genEnB), .done(doneB)
   );

   // host first, then gather/scatter, then the generator
   assign ramAddrA = valid ? addr :
                     extB ? inB[memAddrW-1:0] :
                     reverseA ? mirror(genAddrA) : genAddrA;
   assign ramAddrB = extA ? inA[memAddrW-1:0] :
                     reverseB ? mirror(genAddrB) : genAddrB;

   assign ramEnA = genEnA | valid;
   assign weA = valid ? we : (genEnA & writeA & ~extA);
   assign weB = genEnB & writeB & ~extB;
   assign ramDataA = valid ? hostData : inA;

   dualPortRam ram_i (
      .clk(clk), .enA(ramEnA), .enB(genEnB), .weA(weA), .weB(weB),
      .addrA(ramAddrA), .addrB(ramAddrB), .dataA(ramDataA), .dataB(inB),
      .qA(outA), .qB(outB)
   );

endmodule

/* source/memCluster.sv */
module memCluster (
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   run,
   input  logic                   hostValid,
   input  logic                   hostWe,
   input  versatDataPkg::hostAddr hostAddr,
   input  versatDataPkg::dataWord hostWdata,
   input  versatDataPkg::dataWord streamIn0,
   input  versatDataPkg::dataWord streamIn1,
   input  memConfigPkg::memConfig config0,
   input  memConfigPkg::memConfig config1,
   output versatDataPkg::dataWord mem0OutA,
   output versatDataPkg::dataWord mem0OutB,
   output versatDataPkg::dataWord mem1OutA,
   output versatDataPkg::dataWord mem1OutB,
   output logic                   done0A,
   output logic                   done0B,
   output logic                   done1A,
   output logic                   done1B
);

   import versatDataPkg::*;

   dataBus bus;
   memAddr hostMemAddr;
   logic   valid0;
   logic   valid1;

   // slot 0 in the low word
   assign bus = {mem1OutB, mem1OutA, mem0OutB, mem0OutA, streamIn1, streamIn0};

   // top address bit picks the memory
   assign hostMemAddr = hostAddr[memAddrW-1:0];
   assign valid0 = hostValid & ~hostAddr[hostAddrW-1];
   assign valid1 = hostValid & hostAddr[hostAddrW-1];

   memoryUnit mem0 (
      .clk(clk), .reset(reset), .run(run), .valid(valid0), .we(hostWe),
      .addr(hostMemAddr), .hostData(hostWdata), .bus(bus), .cfg(config0),
      .outA(mem0OutA), .outB(mem0OutB), .doneA(done0A), .doneB(done0B)
   );

   memoryUnit mem1 (
      .clk(clk), .reset(reset), .run(run), .valid(valid1), .we(hostWe),
      .addr(hostMemAddr), .hostData(hostWdata), .bus(bus), .cfg(config1),
      .outA(mem1OutA), .outB(mem1OutB), .doneA(done1A), .doneB(done1B)
   );

endmodule

/* test/memClusterTb.sv */
module memClusterTb;

   import versatDataPkg::*;
   import memConfigPkg::*;

   logic                 clk;
   logic                 reset;
   logic                 run;
   logic                 hostValid;
   logic                 hostWe;
   logic [hostAddrW-1:0] hostAddress;
   dataWord              hostWriteData;
   dataWord              streamIn0;
   dataWord              streamIn1;
   memConfig             config0;
   memConfig             config1;
   dataWord              mem0OutA, mem0OutB, mem1OutA, mem1OutB;
   logic                 done0A, done0B, done1A, done1B;

   // reference contents, stream values per step after run
   dataWord refMem [2][64];
   dataWord log0 [64];
   dataWord log1 [64];
   int      pIter [4];
   int      pPeriod [4];
   int      pDelay [4];
   int      busy [4];
   dataWord readExp;
   dataWord pipeExp;
   logic    pipeMem;
   logic    readPipe;
   logic    checkB;
   dataWord expB0;
   dataWord expB1;
   logic [3:0] doneVec;
   logic [3:0] expDone;

   memCluster dut_i (
      .clk(clk), .reset(reset), .run(run), .hostValid(hostValid), .hostWe(hostWe),
      .hostAddr(hostAddress), .hostWdata(hostWriteData),
      .streamIn0(streamIn0), .streamIn1(streamIn1), .config0(config0), .config1(config1),
      .mem0OutA(mem0OutA), .mem0OutB(mem0OutB), .mem1OutA(mem1OutA), .mem1OutB(mem1OutB),
      .done0A(done0A), .done0B(done0B), .done1A(done1A), .done1B(done1B)
   );

   always #5 clk = ~clk;

   task automatic abortRun(string why);
      $display("%s", why);
      $display("TESTBENCH FAILED");
      $fatal(1);
   endtask

   // ports 0 to 3 are mem0 A, mem0 B, mem1 A, mem1 B
   always @(posedge clk)
   begin
      for (int p = 0; p < 4; p++)
      begin
         if (reset)
            busy[p] <= 0;
         else if (run && pIter[p] != 0)
            busy[p] <= pDelay[p] + pIter[p] * pPeriod[p];
         else if (busy[p] != 0)
            busy[p] <= busy[p] - 1;
      end
   end

   assign doneVec = {done0A, done0B, done1A, done1B};
   assign expDone = {busy[0] == 0, busy[1] == 0, busy[2] == 0, busy[3] == 0};

   // host read data shows up one edge later
   always @(posedge clk)
   begin
      if (reset)
         readPipe <= 1'b0;
      else
         readPipe <= hostValid & ~hostWe;
      pipeMem <= hostAddress[hostAddrW-1];
      pipeExp <= readExp;
   end

   assert property (@(posedge clk) disable iff (reset) doneVec == expDone)
   else
      abortRun($sformatf("MISMATCH at %0t: done %b, expected %b",
         $time, $sampled(doneVec), $sampled(expDone)));

   assert property (@(posedge clk) disable iff (reset)
      readPipe |-> ((pipeMem ? mem1OutA : mem0OutA) == pipeExp))
   else
      abortRun($sformatf("MISMATCH at %0t: mem%0d read %h, expected %h", $time,
         $sampled(pipeMem), $sampled(pipeMem ? mem1OutA : mem0OutA), $sampled(pipeExp)));

   assert property (@(posedge clk) disable iff (reset)
      checkB |-> (mem0OutB == expB0 && mem1OutB == expB1))
   else
      abortRun($sformatf("MISMATCH at %0t: port B read %h %h, expected %h %h", $time,
         $sampled(mem0OutB), $sampled(mem1OutB), $sampled(expB0), $sampled(expB1)));

   function automatic memAddr genAddr(int start, int shift, int incr, int i, int j);
      return memAddr'((start + i * shift + j * incr) % 64);
   endfunction

   function automatic memAddr reverseBits(memAddr a);
      memAddr r;
      for (int b = 0; b < memAddrW; b++)
         r[b] = a[memAddrW-1-b];
      return r;
   endfunction

   task automatic clearConfig();
      config0 = '0;
      config1 = '0;
      for (int p = 0; p < 4; p++)
      begin
         pIter[p] = 0;
         pPeriod[p] = 0;
         pDelay[p] = 0;
      end
   endtask

   task automatic configPort(int p, int iter, int period, int duty, int sel, int start,
      int shift, int incr, int delay, bit rev, bit ext, bit wr);
      portConfig w;
      w = {6'(iter), 5'(period), 5'(duty), 3'(sel), 6'(start), 6'(shift), 6'(incr),
           5'(delay), rev, ext, wr};
      pIter[p] = iter;
      pPeriod[p] = period;
      pDelay[p] = delay;
      case (p)
         0: config0[portConfigW +: portConfigW] = w;
         1: config0[0 +: portConfigW] = w;
         2: config1[portConfigW +: portConfigW] = w;
         default: config1[0 +: portConfigW] = w;
      endcase
   endtask

   task automatic hostWrite(logic [hostAddrW-1:0] a, dataWord d);
      hostValid = 1'b1;
      hostWe = 1'b1;
      hostAddress = a;
      hostWriteData = d;
      refMem[a[hostAddrW-1]][a[memAddrW-1:0]] = d;
      @(posedge clk);
      #1;
   endtask

   task automatic hostRead(logic [hostAddrW-1:0] a);
      hostValid = 1'b1;
      hostWe = 1'b0;
      hostAddress = a;
      readExp = refMem[a[hostAddrW-1]][a[memAddrW-1:0]];
      @(posedge clk);
      #1;
   endtask

   task automatic hostRelease();
      hostValid = 1'b0;
      hostWe = 1'b0;
      @(posedge clk);
      #1;
   endtask

   task automatic readAll();
      for (int a = 0; a < 128; a++)
         hostRead(7'(a));
      hostRelease();
   endtask

   // pulse run, then feed one logged stream word per cycle until all ports finish
   task automatic runPattern();
      int steps;
      steps = 0;
      run = 1'b1;
      @(posedge clk);
      #1;
      run = 1'b0;
      while (!(done0A && done0B && done1A && done1B))
      begin
         if (steps == 60)
            abortRun("timeout: done outputs did not return high after run");
         else
         begin
            streamIn0 = log0[steps];
            streamIn1 = log1[steps];
            steps++;
            @(posedge clk);
            #1;
         end
      end
   endtask

   // both B ports walk every word, each read checked on the following edge
   task automatic scanPortB();
      clearConfig();
      configPort(1, 4, 16, 16, 7, 0, 16, 1, 0, 1'b0, 1'b0, 1'b0);
      configPort(3, 4, 16, 16, 7, 0, 16, 1, 0, 1'b0, 1'b0, 1'b0);
      run = 1'b1;
      @(posedge clk);
      #1;
      run = 1'b0;
      @(posedge clk);
      #1;
      for (int s = 0; s < 64; s++)
      begin
         expB0 = refMem[0][s];
         expB1 = refMem[1][s];
         checkB = 1'b1;
         @(posedge clk);
         #1;
      end
      checkB = 1'b0;
   endtask

   task automatic fillLogs();
      for (int s = 0; s < 64; s++)
      begin
         log0[s] = $urandom;
         log1[s] = $urandom;
      end
   endtask

   initial
   begin
      dataWord c;
      void'($urandom(32'h08bc58cf));
      clk = 1'b0;
      reset = 1'b1;
      run = 1'b0;
      hostValid = 1'b0;
      hostWe = 1'b0;
      hostAddress = '0;
      hostWriteData = '0;
      streamIn0 = '0;
      streamIn1 = '0;
      checkB = 1'b0;
      expB0 = '0;
      expB1 = '0;
      clearConfig();
      repeat (5) @(posedge clk);
      #1;
      reset = 1'b0;
      @(posedge clk);
      #1;

      // host load, then random overwrites
      for (int a = 0; a < 128; a++)
         hostWrite(7'(a), $urandom);
      for (int n = 0; n < 60; n++)
         hostWrite(7'($urandom), $urandom);
      hostRelease();
      readAll();

      // copy mem0 0..15 to mem1 32..47 over the bus
      clearConfig();
      fillLogs();
      configPort(0, 1, 16, 16, 7, 0, 0, 1, 0, 1'b0, 1'b0, 1'b0);
      configPort(3, 1, 16, 16, 2, 32, 0, 1, 1, 1'b0, 1'b0, 1'b1);
      runPattern();
      for (int j = 0; j < 16; j++)
         refMem[1][32+j] = refMem[0][j];
      readAll();

      // 2D walk with a gap in each period
      clearConfig();
      c = $urandom;
      for (int s = 0; s < 64; s++)
         log0[s] = c;
      configPort(3, 3, 6, 4, 0, 5, 10, 3, 3, 1'b0, 1'b0, 1'b1);
      runPattern();
      for (int i = 0; i < 3; i++)
         for (int j = 0; j < 4; j++)
            refMem[1][genAddr(5, 10, 3, i, j)] = c;
      readAll();

      // bit reversed sequential write from stream 1
      clearConfig();
      fillLogs();
      configPort(0, 2, 16, 16, 1, 0, 16, 1, 0, 1'b1, 1'b0, 1'b1);
      runPattern();
      for (int i = 0; i < 2; i++)
         for (int j = 0; j < 16; j++)
            refMem[0][reverseBits(genAddr(0, 16, 1, i, j))] = log1[i*16+j];
      readAll();

      // gather: stream 0 indexes mem0, copied into mem1 48..55
      clearConfig();
      fillLogs();
      configPort(0, 1, 8, 8, 7, 0, 0, 1, 0, 1'b0, 1'b0, 1'b0);
      configPort(1, 0, 0, 0, 0, 0, 0, 0, 0, 1'b0, 1'b1, 1'b0);
      configPort(3, 1, 8, 8, 2, 48, 0, 1, 1, 1'b0, 1'b0, 1'b1);
      runPattern();
      for (int s = 0; s < 8; s++)
         refMem[1][48+s] = refMem[0][log0[s][memAddrW-1:0]];
      readAll();

      // final contents through the B outputs
      scanPortB();

      clearConfig();
      repeat (3) @(posedge clk);
      #1;
      $display("TESTBENCH PASSED");
      $finish;
   end

endmodule

/* memCluster.f */
source/versatDataPkg.sv
source/memConfigPkg.sv
source/dataBusSelect.sv
source/addressGenerator.sv
source/dualPortRam.sv
source/memoryUnit.sv
source/memCluster.sv
test/memClusterTb.sv

/* run.sh */
#!/bin/sh
# compile and run the memCluster testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing --assert -f memCluster.f --top-module memClusterTb -o memClusterSim
if [ $? -ne 0 ]; then
   echo "Verilator compile failed"
   exit 1
fi

./obj_dir/memClusterSim > sim.log 2>&1
simStatus=$?
cat sim.log

if grep -q "TESTBENCH FAILED" sim.log; then
   exit 1
fi
if [ $simStatus -ne 0 ]; then
   echo "simulation exited with status $simStatus"
   exit 1
fi
exit 0
